// File: audio_frontend.f
sample_pkg.sv
window_pkg.sv
sample_trigger.sv
sample_conditioner.sv
window_framer.sv
audio_frontend.sv
tb_clock.sv
audio_frontend_props.sv
audio_frontend_tb.sv

// File: audio_frontend.sv
`timescale 1ns/1ps

module audio_frontend #(
	parameter int CYCLES_PER_TRIGGER = 6250,
	parameter int WINDOW_SIZE = 400,
	parameter int WINDOW_OVERLAP = 160
) (
	input logic clk_pixel,
	input logic sys_rst,
	input sample_pkg::adc_sample_s adc_in,
	output logic sample_trigger,
	output window_pkg::window_beat_s window_out
);
	import sample_pkg::*;

	// requires WINDOW_OVERLAP <= WINDOW_SIZE < CYCLES_PER_TRIGGER,
	// so a window stream is over before the next code can arrive

	// conditioned sample stream, conditioner to framer
	cond_sample_s cond;

	// sample-rate pulse for the external ADC controller
	// at 6250 cycles per trigger this gives 16 kHz on the pixel clock
	sample_trigger #(
		.CYCLES_PER_TRIGGER(CYCLES_PER_TRIGGER)
	) trigger0 (
		.clk_pixel(clk_pixel),
		.sys_rst(sys_rst),
		.trigger(sample_trigger)
	);

	// offset compensation and pre-emphasis
	// one cycle of latency
	sample_conditioner conditioner0 (
		.clk_pixel(clk_pixel),
		.sys_rst(sys_rst),
		.adc_in(adc_in),
		.cond(cond)
	);

	// overlapping windows
	// 400 samples is 25 ms, a new window every 160 samples is 10 ms
	// first beat two cycles after the completing adc_in valid
	window_framer #(
		.WINDOW_SIZE(WINDOW_SIZE),
		.WINDOW_OVERLAP(WINDOW_OVERLAP)
	) framer0 (
		.clk_pixel(clk_pixel),
		.sys_rst(sys_rst),
		.cond(cond),
		.window_out(window_out)
	);

endmodule

// File: audio_frontend_props.sv
`timescale 1ns/1ps

module audio_frontend_props (
	input logic clk_pixel,
	input logic sys_rst,
	input sample_pkg::adc_sample_s adc_in,
	input logic sample_trigger,
	input window_pkg::window_beat_s window_out
);

	// fetch pulse is a single cycle
	trigger_one_cycle: assert property (
		@(posedge clk_pixel) disable iff (sys_rst)
		sample_trigger |=> !sample_trigger
	) else $error("sample_trigger high on two consecutive cycles");

	// first marks a valid beat, and only the opening beat of a stream
	first_opens_stream: assert property (
		@(posedge clk_pixel) disable iff (sys_rst)
		window_out.first |-> window_out.valid && !$past(window_out.valid)
	) else $error("window_out.first not on the opening beat of a stream");

	// no new code while a window streams, there is no back-pressure
	no_code_during_stream: assert property (
		@(posedge clk_pixel) disable iff (sys_rst)
		!(adc_in.valid && window_out.valid)
	) else $error("adc_in.valid while window_out.valid is high");

endmodule

bind audio_frontend audio_frontend_props props0 (
	.clk_pixel(clk_pixel),
	.sys_rst(sys_rst),
	.adc_in(adc_in),
	.sample_trigger(sample_trigger),
	.window_out(window_out)
);

// File: audio_frontend_tb.sv
`timescale 1ns/1ps

module audio_frontend_tb;
	import sample_pkg::*;
	import window_pkg::*;

	// small settings so windows come quickly
	localparam int CPT = 500;
	localparam int WS = 12;
	localparam int WO = 4;
	localparam int clk_period_ns = 4;
	localparam int reset_hold = 4;

	// test lengths in samples, also sizes the watchdog
	localparam int trig_periods = 11;
	localparam int step_windows = 6;
	localparam int overlap_windows = 3;
	localparam int total_samples = trig_periods + WO * (1 + step_windows + overlap_windows + 4) + 2;
	localparam longint watchdog_ns = longint'(total_samples) * CPT * clk_period_ns * 2;
	localparam logic [adc_bits-1:0] step_code = 10'h100;

	logic clk_pixel;
	logic power_on_rst;
	logic rst_req;
	logic sys_rst;
	adc_sample_s adc_in;
	logic sample_trigger;
	window_beat_s window_out;

	int errors;
	int n_checks;

	// reference model state
	int mx_prev;
	int mo_prev;
	// last WS model outputs, oldest first
	int hist [$];
	// beats of the last captured window
	int got_win [WS];

	assign sys_rst = power_on_rst | rst_req;

	tb_clock #(
		.PERIOD_NS(clk_period_ns),
		.RESET_CYCLES(8)
	) clock0 (
		.clk_pixel(clk_pixel),
		.power_on_rst(power_on_rst)
	);

	audio_frontend #(
		.CYCLES_PER_TRIGGER(CPT),
		.WINDOW_SIZE(WS),
		.WINDOW_OVERLAP(WO)
	) dut0 (
		.clk_pixel(clk_pixel),
		.sys_rst(sys_rst),
		.adc_in(adc_in),
		.sample_trigger(sample_trigger),
		.window_out(window_out)
	);

	task automatic check_equal(input int got, input int exp, input string what);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
		end
	endtask

	function automatic int magnitude(input int v);
		return (v < 0) ? -v : v;
	endfunction

	// empty filter, window of zeros
	task automatic model_reset();
		mx_prev = 0;
		mo_prev = 0;
		hist.delete();
		for (int k = 0; k < WS; k++) begin
			hist.push_back(0);
		end
	endtask

	// one accepted code through offset filter and pre-emphasis
	task automatic model_push(input logic [adc_bits-1:0] code);
		int x;
		int o;
		int y;
		longint o_wide;
		longint y_wide;
		// code into the top bits, its msb is the sign
		x = int'(32'(code) << align_shift);
		o_wide = longint'(x) - longint'(mx_prev) + longint'(mo_prev)
			- longint'(mo_prev >>> offset_shift);
		o = int'(o_wide);
		y_wide = longint'(mo_prev) - longint'(o) + longint'(o >>> emph_shift);
		y = int'(y_wide);
		mx_prev = x;
		mo_prev = o;
		hist.push_back(y);
		void'(hist.pop_front());
	endtask

	// wait for the fetch pulse, then hand over one code
	task automatic send_code(input logic [adc_bits-1:0] value);
		int waited;
		waited = 0;
		@(negedge clk_pixel);
		while (!sample_trigger && waited < CPT + 8) begin
			@(negedge clk_pixel);
			waited++;
		end
		if (!sample_trigger) begin
			errors++;
			$display("no sample_trigger pulse within %0d cycles", waited);
			return;
		end
		@(posedge clk_pixel);
		adc_in.code <= value;
		adc_in.valid <= 1'b1;
		@(posedge clk_pixel);
		adc_in.valid <= 1'b0;
		model_push(value);
	endtask

	// capture one window stream and compare with the model history
	task automatic collect_window(input string what);
		int waited;
		waited = 1;
		@(negedge clk_pixel);
		while (!window_out.valid && waited < WS + 8) begin
			@(negedge clk_pixel);
			waited++;
		end
		if (!window_out.valid) begin
			errors++;
			$display("%s: window stream did not start within %0d cycles", what, waited);
			return;
		end
		// two cycles after the completing code
		check_equal(waited, 2, {what, " start latency"});
		for (int k = 0; k < WS; k++) begin
			got_win[k] = int'(window_out.data);
			check_equal(int'(window_out.valid), 1, $sformatf("%s beat %0d valid", what, k));
			check_equal(int'(window_out.first), int'(k == 0),
				$sformatf("%s beat %0d first", what, k));
			check_equal(got_win[k], hist[k], $sformatf("%s beat %0d data", what, k));
			@(negedge clk_pixel);
		end
		check_equal(int'(window_out.valid), 0, {what, " valid after last beat"});
	endtask

	task automatic report_test(input string name, input int errs0, input int checks0);
		$display("test %s: %0d checks, %0d errors", name, n_checks - checks0, errors - errs0);
	endtask

	task automatic measure_trigger_period();
		int errs0;
		int checks0;
		int n;
		errs0 = errors;
		checks0 = n_checks;
		@(negedge clk_pixel);
		while (sys_rst) begin
			@(negedge clk_pixel);
		end
		// n counts cycles since reset release
		n = 1;
		while (!sample_trigger && n < CPT + 10) begin
			@(negedge clk_pixel);
			n++;
		end
		check_equal(n, CPT, "first trigger position");
		for (int p = 0; p < trig_periods - 1; p++) begin
			@(negedge clk_pixel);
			check_equal(int'(sample_trigger), 0, "trigger pulse width");
			n = 1;
			while (!sample_trigger && n < CPT + 10) begin
				@(negedge clk_pixel);
				n++;
			end
			check_equal(n, CPT, $sformatf("trigger period %0d", p));
		end
		report_test("trigger_period", errs0, checks0);
	endtask

	task automatic verify_first_window();
		int errs0;
		int checks0;
		errs0 = errors;
		checks0 = n_checks;
		for (int i = 0; i < WO; i++) begin
			send_code(10'(16 * (i + 1)));
		end
		collect_window("first window");
		// zero padding in front of the new samples
		for (int k = 0; k < WS - WO; k++) begin
			check_equal(got_win[k], 0, $sformatf("first window padding beat %0d", k));
		end
		report_test("first_window", errs0, checks0);
	endtask

	task automatic drive_step();
		int errs0;
		int checks0;
		int early_mag;
		int late_mag;
		errs0 = errors;
		checks0 = n_checks;
		early_mag = 0;
		late_mag = 0;
		for (int w = 0; w < step_windows; w++) begin
			for (int i = 0; i < WO; i++) begin
				send_code(step_code);
			end
			collect_window($sformatf("step window %0d", w));
			if (w == 0) begin
				early_mag = magnitude(got_win[WS-1]);
			end
			late_mag = magnitude(got_win[WS-1]);
		end
		// dc level leaks away, newest sample keeps shrinking
		check_equal(int'(late_mag < early_mag), 1, "step response decays");
		report_test("step", errs0, checks0);
	endtask

	task automatic overlap_random_windows();
		int errs0;
		int checks0;
		int prev_exp [WS];
		errs0 = errors;
		checks0 = n_checks;
		for (int w = 0; w < overlap_windows; w++) begin
			for (int k = 0; k < WS; k++) begin
				prev_exp[k] = hist[k];
			end
			for (int i = 0; i < WO; i++) begin
				send_code(10'($urandom));
			end
			collect_window($sformatf("overlap window %0d", w));
			// older part is the tail of the previous window
			for (int k = 0; k < WS - WO; k++) begin
				check_equal(got_win[k], prev_exp[k + WO], $sformatf("overlap beat %0d", k));
			end
		end
		report_test("overlap", errs0, checks0);
	endtask

	task automatic exercise_sign_and_reset();
		int errs0;
		int checks0;
		int waited;
		errs0 = errors;
		checks0 = n_checks;
		// top bit set on every code
		for (int i = 0; i < WO; i++) begin
			send_code(10'h200 + 10'(i * 83));
		end
		collect_window("negative window");
		// another group, then reset in the middle of its stream
		for (int i = 0; i < WO; i++) begin
			send_code(10'($urandom));
		end
		waited = 0;
		@(negedge clk_pixel);
		while (!window_out.valid && waited < WS + 8) begin
			@(negedge clk_pixel);
			waited++;
		end
		if (!window_out.valid) begin
			errors++;
			$display("window stream before reset did not start");
		end
		repeat (2) @(negedge clk_pixel);
		@(posedge clk_pixel);
		rst_req <= 1'b1;
		repeat (2) @(negedge clk_pixel);
		check_equal(int'(window_out.valid), 0, "valid cleared by reset");
		check_equal(int'(window_out.first), 0, "first cleared by reset");
		repeat (reset_hold) @(posedge clk_pixel);
		rst_req <= 1'b0;
		model_reset();
		for (int w = 0; w < 2; w++) begin
			for (int i = 0; i < WO; i++) begin
				send_code(10'($urandom));
			end
			collect_window($sformatf("after reset window %0d", w));
			if (w == 0) begin
				for (int k = 0; k < WS - WO; k++) begin
					check_equal(got_win[k], 0, $sformatf("padding after reset beat %0d", k));
				end
			end
		end
		report_test("sign_and_reset", errs0, checks0);
	endtask

	// hard limit on run time
	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, run did not finish", watchdog_ns);
		$display("Regression failed");
		$finish;
	end

	initial begin
		void'($urandom(32'ha681));
		adc_in = '0;
		rst_req = 1'b0;
		errors = 0;
		n_checks = 0;
		model_reset();
		measure_trigger_period();
		verify_first_window();
		drive_step();
		overlap_random_windows();
		exercise_sign_and_reset();
		$display("total: %0d checks, %0d errors", n_checks, errors);
		if (errors == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the audio front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module audio_frontend_tb \
	-f audio_frontend.f \
	-o audio_frontend_sim

out=$(./obj_dir/audio_frontend_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Regression passed"; then
	exit 0
fi
exit 1

// File: sample_conditioner.sv
`timescale 1ns/1ps

module sample_conditioner (
	input logic clk_pixel,
	input logic sys_rst,
	input sample_pkg::adc_sample_s adc_in,
	output sample_pkg::cond_sample_s cond
);
	import sample_pkg::*;

	// filter state, x(n-1) and o(n-1)
	sample_t x_prev;
	sample_t o_prev;

	// current sample through the chain
	sample_t x_cur;
	sample_t o_cur;
	sample_t y_cur;

	// registered output
	sample_t y_q;
	logic valid_q;

	// left-align the code into the sample word
	// top ADC bit becomes the sign
	assign x_cur = {adc_in.code, {align_shift{1'b0}}};

	always_comb begin
		// offset compensation
		// o(n) = x(n) - x(n-1) + o(n-1) - o(n-1)/1024
		// leaky difference, pulls any dc level back to zero
		o_cur = x_cur - x_prev + o_prev - (o_prev >>> offset_shift);

		// pre-emphasis on the offset-free signal
		// y(n) = o(n-1) - o(n) + o(n)/32
		y_cur = o_prev - o_cur + (o_cur >>> emph_shift);
	end

	// filter state only moves on an accepted code
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			x_prev <= '0;
			o_prev <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= adc_in.valid;
			if (adc_in.valid) begin
				x_prev <= x_cur;
				o_prev <= o_cur;
			end
		end
	end

	// output sample, one cycle behind the code
	always_ff @(posedge clk_pixel) begin
		if (adc_in.valid) begin
			y_q <= y_cur;
		end
	end

	assign cond = '{data: y_q, valid: valid_q};

endmodule

// File: sample_pkg.sv
package sample_pkg;

	// conditioned audio sample width
	localparam int sample_bits = 32;
	// raw code width from the serial ADC
	localparam int adc_bits = 10;

	typedef logic signed [sample_bits-1:0] sample_t;
	typedef logic [adc_bits-1:0] adc_code_t;

	// left-align the ADC code, top ADC bit lands on the sign bit
	localparam int align_shift = sample_bits - adc_bits;
	// leak of the offset filter, roughly 1/1024 per sample
	localparam int offset_shift = 10;
	// pre-emphasis coefficient 1 - 1/32
	localparam int emph_shift = 5;

	// ADC code with its conversion-done strobe
	typedef struct packed {
		adc_code_t code;
		logic valid;
	} adc_sample_s;

	// conditioned sample with its strobe
	typedef struct packed {
		sample_t data;
		logic valid;
	} cond_sample_s;

endpackage

// File: sample_trigger.sv
`timescale 1ns/1ps

module sample_trigger #(
	parameter int CYCLES_PER_TRIGGER = 6250
) (
	input logic clk_pixel,
	input logic sys_rst,
	output logic trigger
);

	// counter wide enough for 0 .. CYCLES_PER_TRIGGER-1
	localparam int CNT_W = $clog2(CYCLES_PER_TRIGGER);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES_PER_TRIGGER - 1);

	logic [CNT_W-1:0] count;

	// free-running cycle counter, wraps at the terminal count
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			count <= '0;
		end else if (count == CNT_LAST) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// one-cycle pulse on the terminal count
	// tells the external ADC controller to start a conversion
	// count sits at zero in reset, so the pulse stays low there
	assign trigger = (count == CNT_LAST);

endmodule

// File: tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int PERIOD_NS = 4,
	parameter int RESET_CYCLES = 8
) (
	output logic clk_pixel,
	output logic power_on_rst
);

	// free-running pixel clock
	initial begin
		clk_pixel = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_pixel = ~clk_pixel;
	end

	// power-on reset, released on a rising edge
	initial begin
		power_on_rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_pixel);
		power_on_rst <= 1'b0;
	end

endmodule

// File: window_framer.sv
`timescale 1ns/1ps

module window_framer #(
	parameter int WINDOW_SIZE = 400,
	parameter int WINDOW_OVERLAP = 160
) (
	input logic clk_pixel,
	input logic sys_rst,
	input sample_pkg::cond_sample_s cond,
	output window_pkg::window_beat_s window_out
);
	import sample_pkg::*;

	// counter widths, one spare value so a size of one still works
	localparam int OV_W = $clog2(WINDOW_OVERLAP + 1);
	localparam int RD_W = $clog2(WINDOW_SIZE + 1);
	localparam logic [OV_W-1:0] OV_LAST = OV_W'(WINDOW_OVERLAP - 1);
	localparam logic [RD_W-1:0] RD_LAST = RD_W'(WINDOW_SIZE - 1);

	// window shift register
	// entry 0 is the newest sample, last entry the oldest
	sample_t win_buf [WINDOW_SIZE];

	// new samples since the last window
	logic [OV_W-1:0] ov_cnt;
	// beat index during readout
	logic [RD_W-1:0] rd_cnt;
	logic streaming;

	// head of the shift register and its enable
	sample_t head;
	logic shift_en;
	// the sample that completes an overlap group
	logic window_done;

	assign window_done = cond.valid && !streaming && (ov_cnt == OV_LAST);

	// during readout the oldest entry wraps round into the newest slot,
	// otherwise the new conditioned sample enters
	assign head = streaming ? win_buf[WINDOW_SIZE-1] : cond.data;
	assign shift_en = streaming || cond.valid;

	// buffer starts as zeros
	// first window comes out zero padded in front
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			for (int i = 0; i < WINDOW_SIZE; i++) begin
				win_buf[i] <= '0;
			end
		end else if (shift_en) begin
			win_buf[0] <= head;
			for (int i = 1; i < WINDOW_SIZE; i++) begin
				win_buf[i] <= win_buf[i-1];
			end
		end
	end

	// overlap count, only new samples advance it
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			ov_cnt <= '0;
		end else if (cond.valid && !streaming) begin
			if (window_done) begin
				ov_cnt <= '0;
			end else begin
				ov_cnt <= ov_cnt + 1'b1;
			end
		end
	end

	// readout control
	// stream begins the cycle after the completing sample
	// and lasts WINDOW_SIZE cycles
	always_ff @(posedge clk_pixel) begin
		if (sys_rst) begin
			streaming <= 1'b0;
			rd_cnt <= '0;
		end else if (streaming) begin
			if (rd_cnt == RD_LAST) begin
				// full rotation done, buffer back in its original order
				streaming <= 1'b0;
				rd_cnt <= '0;
			end else begin
				rd_cnt <= rd_cnt + 1'b1;
			end
		end else if (window_done) begin
			streaming <= 1'b1;
			rd_cnt <= '0;
		end
	end

	// beat k is the k-th oldest sample
	// because each rotation brings the next oldest to the tail
	assign window_out = '{
		data: win_buf[WINDOW_SIZE-1],
		valid: streaming,
		first: streaming && (rd_cnt == '0)
	};

endmodule

// File: window_pkg.sv
package window_pkg;

	// one beat of a streamed analysis window
	// beats of one window come back to back, oldest sample first
	typedef struct packed {
		// pre-emphasised sample
		sample_pkg::sample_t data;
		// high on every beat of the stream
		logic valid;
		// marks beat 0, the oldest sample of the window
		logic first;
	} window_beat_s;

	// the next stage (FFT input) only needs first and valid to frame a window,
	// beat count follows from the window size

endpackage
